/* common/alu_pkg.sv */
// ALU package
// Word width, opcode encodings, saturation limits and the operand
// word type shared by the execution units of the 16-bit ALU

package alu_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////
  localparam int data_width  = 16;                      // ALU word width
  localparam int op_width    = 4;                       // Opcode field width
  localparam int nib_width   = 4;                       // One signed nibble
  localparam int nib_count   = data_width / nib_width;  // Nibbles per word
  localparam int byte_width  = 8;                       // Byte replaced by LLB/LHB
  localparam int shamt_width = 4;                       // Shift amount taken from B
  localparam int red_width   = 7;                       // Fits a sum of eight signed nibbles

  ////////////////////////////////////////
  // Saturation limits
  ////////////////////////////////////////
  // Full word clamps for ADD/SUB
  localparam logic [data_width-1:0] sat_max = 16'h7FFF;
  localparam logic [data_width-1:0] sat_min = 16'h8000;

  // Per-nibble clamps for PADDSB
  localparam logic [nib_width-1:0] nib_sat_max = 4'h7;  // +7
  localparam logic [nib_width-1:0] nib_sat_min = 4'h8;  // -8

  ////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////
  localparam logic [op_width-1:0] op_add    = 4'h0;  // Saturating add
  localparam logic [op_width-1:0] op_sub    = 4'h1;  // Saturating subtract
  localparam logic [op_width-1:0] op_xor    = 4'h2;
  localparam logic [op_width-1:0] op_red    = 4'h3;  // Nibble reduction
  localparam logic [op_width-1:0] op_sll    = 4'h4;
  localparam logic [op_width-1:0] op_sra    = 4'h5;
  localparam logic [op_width-1:0] op_ror    = 4'h6;
  localparam logic [op_width-1:0] op_paddsb = 4'h7;  // Parallel nibble add
  localparam logic [op_width-1:0] op_lw     = 4'h8;  // Load address
  localparam logic [op_width-1:0] op_sw     = 4'h9;  // Store address
  localparam logic [op_width-1:0] op_llb    = 4'hA;  // Load low byte
  localparam logic [op_width-1:0] op_lhb    = 4'hB;  // Load high byte
  // 4'hC to 4'hF are unused and flagged as errors

  ////////////////////////////////////////
  // Operand word
  ////////////////////////////////////////
  // Same 16 bits seen either as one word (ADD, SUB, address)
  // or as four signed nibbles (RED, PADDSB)
  typedef union packed {
    logic [data_width-1:0]               word;  // Whole word view
    logic [nib_count-1:0][nib_width-1:0] nib;   // nib[0] is bits 3:0
  } alu_word_u;

endpackage

/* common/alu_op_if.sv */
// Operation bus
// Carries one ALU operation from the top level to both units

interface alu_op_if import alu_pkg::*; ();

  logic [op_width-1:0] opcode;     // Operation select
  alu_word_u           operand_a;  // First operand
  alu_word_u           operand_b;  // Second operand
  logic                issue;      // Operation accepted this cycle

  // Top level drives the whole bus
  modport source (
    output opcode,
    output operand_a,
    output operand_b,
    output issue
  );

  // Units decode and compute from the operation alone
  modport unit (
    input opcode,
    input operand_a,
    input operand_b
  );

endinterface

/* arith/arith_unit.sv */
// Arithmetic unit
// Saturating ADD/SUB, LW/SW address generation, RED reduction
// and PADDSB parallel nibble add, all combinational

module arith_unit import alu_pkg::*; (
  alu_op_if.unit                op,            // Operation in
  output logic [data_width-1:0] arith_result,  // Result for a claimed opcode
  output logic                  arith_claim,   // Opcode belongs to this unit
  output logic                  saturate       // ADD/SUB clamped
);

  alu_word_u             a, b;                 // Operands in both views
  logic                  is_sub;
  logic                  b_sign;               // Sign of the effective addend
  logic                  pos_ov, neg_ov;       // Overflow direction
  logic [data_width-1:0] sum_raw, sum_sat;
  logic [data_width-1:0] addr_sum;             // LW/SW address
  logic [red_width-1:0]  red_sum;              // Running RED total
  logic [nib_count-1:0][nib_width-1:0] nib_sum;  // Wrapped nibble sums
  alu_word_u             paddsb_res;

  assign a = op.operand_a;
  assign b = op.operand_b;

  ////////////////////////////////////////
  // ADD / SUB with saturation
  ////////////////////////////////////////
  assign is_sub  = (op.opcode == op_sub);
  assign sum_raw = is_sub ? a.word - b.word : a.word + b.word;
  assign b_sign  = is_sub ? ~b.word[data_width-1] : b.word[data_width-1];  // B negated for SUB

  // Same-sign inputs giving opposite-sign output
  assign pos_ov  = ~a.word[data_width-1] & ~b_sign & sum_raw[data_width-1];
  assign neg_ov  = a.word[data_width-1] & b_sign & ~sum_raw[data_width-1];
  assign sum_sat = pos_ov ? sat_max : (neg_ov ? sat_min : sum_raw);

  // Word aligned base plus word offset, wraps freely
  assign addr_sum = {a.word[data_width-1:1], 1'b0} + {b.word[data_width-2:0], 1'b0};

  ////////////////////////////////////////
  // Nibble datapath
  ////////////////////////////////////////
  // RED sums all eight nibbles as signed values
  always_comb begin
    red_sum = '0;
    for (int i = 0; i < nib_count; i++) begin
      red_sum = red_sum + {{(red_width-nib_width){a.nib[i][nib_width-1]}}, a.nib[i]};
      red_sum = red_sum + {{(red_width-nib_width){b.nib[i][nib_width-1]}}, b.nib[i]};
    end
  end

  // PADDSB clamps each lane on its own
  always_comb begin
    for (int i = 0; i < nib_count; i++) begin
      nib_sum[i] = a.nib[i] + b.nib[i];  // Wraps inside the lane
      if (~a.nib[i][nib_width-1] & ~b.nib[i][nib_width-1] & nib_sum[i][nib_width-1])
        paddsb_res.nib[i] = nib_sat_max;  // Positive overflow
      else if (a.nib[i][nib_width-1] & b.nib[i][nib_width-1] & ~nib_sum[i][nib_width-1])
        paddsb_res.nib[i] = nib_sat_min;  // Negative overflow
      else
        paddsb_res.nib[i] = nib_sum[i];
    end
  end

  ////////////////////////////////////////
  // Decode and select
  ////////////////////////////////////////
  always_comb begin
    arith_claim  = 1'b1;
    arith_result = '0;
    case (op.opcode)
      op_add, op_sub: arith_result = sum_sat;
      op_lw, op_sw:   arith_result = addr_sum;
      op_red:         arith_result = {{(data_width-red_width){red_sum[red_width-1]}}, red_sum};
      op_paddsb:      arith_result = paddsb_res.word;
      default: begin
        arith_claim = 1'b0;  // Logic unit opcode or unused
      end
    endcase
  end

  // Only ADD and SUB report clamping
  assign saturate = ((op.opcode == op_add) | is_sub) & (pos_ov | neg_ov);

endmodule

/* shift/logic_shift_unit.sv */
// Logic and shift unit
// XOR, SLL/SRA/ROR by the low bits of B and the LLB/LHB byte loads
// Purely combinational

module logic_shift_unit import alu_pkg::*; (
  alu_op_if.unit                op,            // Operation in
  output logic [data_width-1:0] logic_result,  // Result for a claimed opcode
  output logic                  logic_claim    // Opcode belongs to this unit
);

  logic [data_width-1:0]   a, b;         // Word view only
  logic [shamt_width-1:0]  shamt;        // Shift and rotate amount
  logic [2*data_width-1:0] rot_pair;     // A twice for the rotate
  logic [data_width-1:0]   xor_res;
  logic [data_width-1:0]   sll_res, sra_res, ror_res;
  logic [data_width-1:0]   llb_res, lhb_res;

  assign a     = op.operand_a.word;
  assign b     = op.operand_b.word;
  assign shamt = b[shamt_width-1:0];

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////
  assign xor_res = a ^ b;

  assign sll_res = a << shamt;           // Zero fill
  assign sra_res = $signed(a) >>> shamt; // Sign fill

  // Bits shifted out of the bottom come back in at the top
  assign rot_pair = {a, a} >> shamt;
  assign ror_res  = rot_pair[data_width-1:0];

  // Byte loads take the low byte of B
  assign llb_res = {a[data_width-1:byte_width], b[byte_width-1:0]};
  assign lhb_res = {b[byte_width-1:0], a[byte_width-1:0]};

  ////////////////////////////////////////
  // Decode and select
  ////////////////////////////////////////
  always_comb begin
    logic_claim  = 1'b1;
    logic_result = '0;
    case (op.opcode)
      op_xor: logic_result = xor_res;
      op_sll: logic_result = sll_res;
      op_sra: logic_result = sra_res;
      op_ror: logic_result = ror_res;
      op_llb: logic_result = llb_res;
      op_lhb: logic_result = lhb_res;
      default: begin
        logic_claim = 1'b0;  // Arithmetic opcode or unused
      end
    endcase
  end

endmodule

/* logic/alu_result_stage.sv */
// Result stage
// Picks the claiming unit's result, derives Z/V/N and error and
// holds them in one output register under a valid/ready handshake

module alu_result_stage import alu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  issue,         // Operation accepted this cycle
  output logic                  in_ready,
  input  logic [data_width-1:0] arith_result,
  input  logic                  arith_claim,
  input  logic                  saturate,
  input  logic [data_width-1:0] logic_result,
  input  logic                  logic_claim,
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic [data_width-1:0] result,
  output logic                  z_set,
  output logic                  v_set,
  output logic                  n_set,
  output logic                  error          // Unused opcode
);

  logic [data_width-1:0] sel_result;  // Result before the register
  logic                  sel_error;
  logic                  sel_z, sel_v, sel_n;

  // Unclaimed opcode gives zero and error
  assign sel_error  = ~arith_claim & ~logic_claim;
  assign sel_result = arith_claim ? arith_result : (logic_claim ? logic_result : '0);

  assign sel_z = (sel_result == '0);
  assign sel_n = sel_result[data_width-1];
  assign sel_v = saturate;  // Clamp reported by the arithmetic unit

  // Room when empty or when the held result leaves this cycle
  assign in_ready = ~out_valid | out_ready;

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      result    <= '0;
      z_set     <= 1'b0;
      v_set     <= 1'b0;
      n_set     <= 1'b0;
      error     <= 1'b0;
    end else if (issue) begin
      out_valid <= 1'b1;        // Load new operation
      result    <= sel_result;
      z_set     <= sel_z;
      v_set     <= sel_v;
      n_set     <= sel_n;
      error     <= sel_error;
    end else if (out_ready) begin
      out_valid <= 1'b0;        // Drained, nothing new
    end
  end

endmodule

/* logic/alu_top.sv */
// ALU top level
// Plain-port wrapper that packs an operation onto the bus, runs both
// units in parallel and registers the result in the result stage

module alu_top import alu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  logic [op_width-1:0]   opcode,
  input  logic [data_width-1:0] operand_a,
  input  logic [data_width-1:0] operand_b,
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic [data_width-1:0] result,
  output logic                  z_set,
  output logic                  v_set,
  output logic                  n_set,
  output logic                  error
);

  logic [data_width-1:0] arith_result, logic_result;
  logic                  arith_claim, logic_claim;
  logic                  saturate;

  alu_op_if op_bus ();

  // Drive the operation bus from the input ports
  assign op_bus.opcode         = opcode;
  assign op_bus.operand_a.word = operand_a;
  assign op_bus.operand_b.word = operand_b;
  assign op_bus.issue          = in_valid & in_ready;  // Transfer this edge

  ////////////////////////////////////////
  // Execution units and result stage
  ////////////////////////////////////////
  arith_unit arith_unit_i (
    .op(op_bus), .arith_result(arith_result), .arith_claim(arith_claim), .saturate(saturate)
  );

  logic_shift_unit logic_shift_unit_i (
    .op(op_bus), .logic_result(logic_result), .logic_claim(logic_claim)
  );

  alu_result_stage alu_result_stage_i (
    .clk(clk), .rst_n(rst_n), .issue(op_bus.issue), .in_ready(in_ready),
    .arith_result(arith_result), .arith_claim(arith_claim), .saturate(saturate),
    .logic_result(logic_result), .logic_claim(logic_claim),
    .out_valid(out_valid), .out_ready(out_ready), .result(result),
    .z_set(z_set), .v_set(v_set), .n_set(n_set), .error(error)
  );

endmodule

/* tb/alu_assertions.sv */
// Result stage assertions
// Output hold under back-pressure, reset state and flag consistency

module alu_assertions import alu_pkg::*; (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  out_valid,
  input logic                  out_ready,
  input logic [data_width-1:0] result,
  input logic                  z_set,
  input logic                  v_set,
  input logic                  n_set,
  input logic                  error
);

  // Stalled output keeps valid, data and flags
  hold_when_stalled: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(result) && $stable({z_set, v_set, n_set, error}))
    else $error("Output changed while stalled");

  reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !out_valid)
    else $error("out_valid high after a reset cycle");

  // Unused opcodes never saturate
  no_error_with_v: assert property (@(posedge clk) disable iff (!rst_n) !(error && v_set))
    else $error("error and v_set high together");

endmodule

bind alu_result_stage alu_assertions alu_assertions_i (
  .clk(clk), .rst_n(rst_n), .out_valid(out_valid), .out_ready(out_ready), .result(result),
  .z_set(z_set), .v_set(v_set), .n_set(n_set), .error(error)
);

/* tb/alu_tb.sv */
// ALU testbench
// Random operations from a fixed seed against a reference model,
// with random back-pressure, an in-order scoreboard and a timeout

module alu_tb;

  localparam int num_ops      = 2000;                       // Operations to issue
  localparam int reset_cycles = 16;
  localparam int cycle_limit  = 4 * num_ops + reset_cycles;  // Timeout bound

  logic        clk, rst_n, in_valid, in_ready, out_valid, out_ready;
  logic [3:0]  opcode;
  logic [15:0] operand_a, operand_b, result;
  logic        z_set, v_set, n_set, error;

  logic [23:0] expected_q[$];  // {opcode, error, v, n, z, result}
  int          cycle_count = 0;
  int          issued, seed_val;
  int          outputs_seen = 0, sat_seen = 0, err_seen = 0, zero_seen = 0;
  logic        accepted_last = 1'b0;

  alu_top alu_top_i (
    .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_ready(in_ready),
    .opcode(opcode), .operand_a(operand_a), .operand_b(operand_b),
    .out_valid(out_valid), .out_ready(out_ready), .result(result),
    .z_set(z_set), .v_set(v_set), .n_set(n_set), .error(error)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////
  task automatic report_failure(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    if (expected !== actual)
      report_failure($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  function automatic int nib_value(input logic [3:0] n);
    return int'($signed(n));  // Signed nibble -8..7
  endfunction

  function automatic logic [23:0] model_alu(input logic [3:0] opc, input logic [15:0] a,
                                            input logic [15:0] b);
    int          sum, lane, sh;
    logic [15:0] res;
    logic        sat, err;
    res = 16'h0000;
    sat = 1'b0;
    err = 1'b0;
    sh  = int'(b[3:0]);
    case (opc)
      4'd0, 4'd1: begin
        sum = (opc == 4'd0) ? int'($signed(a)) + int'($signed(b))
                            : int'($signed(a)) - int'($signed(b));
        if (sum > 32767) begin            // Clamp high
          res = 16'h7FFF;
          sat = 1'b1;
        end else if (sum < -32768) begin  // Clamp low
          res = 16'h8000;
          sat = 1'b1;
        end else begin
          res = sum[15:0];
        end
      end
      4'd2: res = a ^ b;
      4'd3: begin
        sum = 0;
        for (int i = 0; i < 4; i++)
          sum = sum + nib_value(a[4*i +: 4]) + nib_value(b[4*i +: 4]);
        res = sum[15:0];  // Sign-extended total
      end
      4'd4: for (int j = 0; j < 16; j++) res[j] = (j >= sh) ? a[j - sh] : 1'b0;
      4'd5: for (int j = 0; j < 16; j++) res[j] = (j + sh > 15) ? a[15] : a[j + sh];
      4'd6: for (int j = 0; j < 16; j++) res[j] = a[(j + sh) % 16];
      4'd7: for (int i = 0; i < 4; i++) begin
        lane = nib_value(a[4*i +: 4]) + nib_value(b[4*i +: 4]);
        if (lane > 7) lane = 7;
        else if (lane < -8) lane = -8;
        res[4*i +: 4] = lane[3:0];
      end
      4'd8, 4'd9: res = (a & 16'hFFFE) + {b[14:0], 1'b0};  // Wraps
      4'd10: res = {a[15:8], b[7:0]};
      4'd11: res = {b[7:0], a[7:0]};
      default: err = 1'b1;  // Unused opcode, result stays zero
    endcase
    return {opc, err, sat, res[15], res == 16'h0000, res};
  endfunction

  // Bias toward the saturation and zero corners
  function automatic logic [15:0] pick_operand();
    case ($urandom_range(0, 7))
      0: return 16'h7FFF;
      1: return 16'h8000;
      2: return 16'h0000;
      3: return 16'hFFFF;
      4: return 16'($urandom_range(0, 15));
      default: return 16'($urandom);
    endcase
  endfunction

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  initial begin
    seed_val  = $urandom(32'h6936_0849);  // Seed once
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    opcode    = 4'h0;
    operand_a = 16'h0000;
    operand_b = 16'h0000;
    out_ready = 1'b0;
    issued    = 0;
    repeat (reset_cycles) @(posedge clk);
    check_value("reset result", 16'h0000, result);
    check_value("reset valid and flags", 16'h0000, 16'({out_valid, z_set, v_set, n_set, error}));
    rst_n <= 1'b1;
    while (issued < num_ops) begin
      @(posedge clk);
      if (in_valid && in_ready) issued = issued + 1;
      if (!in_valid || in_ready) begin  // Hold an offered operation until taken
        if (issued < num_ops && $urandom_range(0, 3) != 0) begin
          in_valid  <= 1'b1;
          opcode    <= 4'($urandom_range(0, 15));
          operand_a <= pick_operand();
          operand_b <= pick_operand();
        end else begin
          in_valid <= 1'b0;
        end
      end
      // First quarter runs without back-pressure
      out_ready <= (issued < num_ops / 4) ? 1'b1 : ($urandom_range(0, 3) != 0);
    end
    out_ready <= 1'b1;  // Drain
    do @(posedge clk); while (out_valid);
    check_value("operations left in flight", 16'd0, 16'(expected_q.size()));
    check_value("operations completed", 16'(num_ops), 16'(outputs_seen));
    check_value("saturation observed", 16'd1, 16'(sat_seen != 0));
    check_value("error observed", 16'd1, 16'(err_seen != 0));
    check_value("zero result observed", 16'd1, 16'(zero_seen != 0));
    $display("*** TEST PASSED ***");
    $finish;
  end

  ////////////////////////////////////////
  // Scoreboard and timeout
  ////////////////////////////////////////
  always @(posedge clk) begin
    logic [23:0] entry;
    if (rst_n) begin
      // Only a held result that is not taken may block new input
      check_value("in_ready under back-pressure", 16'(!(out_valid && !out_ready)),
                  16'(in_ready));
      if (accepted_last)
        check_value("out_valid one cycle after accept", 16'd1, 16'(out_valid));
      if (out_valid && out_ready) begin
        if (expected_q.size() == 0) begin
          report_failure("Output transfer with no accepted operation outstanding");
        end else begin
          entry = expected_q.pop_front();
          check_value($sformatf("opcode %0d result", entry[23:20]), entry[15:0], result);
          check_value($sformatf("opcode %0d flags evnz", entry[23:20]), 16'(entry[19:16]),
                      16'({error, v_set, n_set, z_set}));
          outputs_seen = outputs_seen + 1;
          if (v_set) sat_seen = sat_seen + 1;
          if (error) err_seen = err_seen + 1;
          if (z_set) zero_seen = zero_seen + 1;
        end
      end
      accepted_last = in_valid && in_ready;
      if (accepted_last) expected_q.push_back(model_alu(opcode, operand_a, operand_b));
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit)
      report_failure($sformatf("Timeout after %0d cycles with operations unfinished", cycle_count));
  end

endmodule

/* alu_core.f */
common/alu_pkg.sv
common/alu_op_if.sv
arith/arith_unit.sv
shift/logic_shift_unit.sv
logic/alu_result_stage.sv
logic/alu_top.sv
tb/alu_assertions.sv
tb/alu_tb.sv

/* run.sh */
#!/bin/sh
# Build the ALU testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module alu_tb -Mdir obj_dir -f alu_core.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Valu_tb)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1
